// ==== include/add_defines.svh ====
// Width and latency macros for the pipelined 32-bit add/subtract unit
`ifndef ADD_DEFINES_SVH
`define ADD_DEFINES_SVH

// Operand and result width
`define ADD_WIDTH 32

// One byte per pipeline slice, fixed by the 8-bit prefix adder
`define ADD_SLICE_WIDTH 8
`define ADD_NUM_SLICES 4

// Operation tag carried alongside each request
`define ADD_TAG_WIDTH 4

// Decode + four slices + flags
`define ADD_LATENCY 6

`endif

// ==== rtl/add_req_pkg.sv ====
// External interface types: opcode enum, request struct and result struct
`include "add_defines.svh"

package add_req_pkg;

    // ------------------------------
    // Opcodes
    // ------------------------------
    // CMP is a subtract that only reports flags
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_ADC = 3'd1,
        OP_SUB = 3'd2,
        OP_SBB = 3'd3,
        OP_CMP = 3'd4
    } add_op_e;

    // ------------------------------
    // Request from the caller
    // ------------------------------
    typedef struct packed {
        add_op_e                   op;
        logic [`ADD_TAG_WIDTH-1:0] tag;
        logic [`ADD_WIDTH-1:0]     a;
        logic [`ADD_WIDTH-1:0]     b;
        // Carry for ADC, borrow for SBB
        logic                      carry_in;
    } add_req_t;

    // ------------------------------
    // Result back to the caller
    // ------------------------------
    typedef struct packed {
        logic [`ADD_TAG_WIDTH-1:0] tag;
        logic [`ADD_WIDTH-1:0]     sum;
        // Low for CMP only
        logic                      write_en;
        logic                      zero;
        logic                      negative;
        // Carry for adds, borrow for subtracts
        logic                      carry;
        logic                      overflow;
    } add_result_t;

endpackage

// ==== rtl/add_beat_pkg.sv ====
// Internal pipeline beat struct passed from stage to stage
`include "add_defines.svh"

package add_beat_pkg;

    // ------------------------------
    // Pipeline beat
    // ------------------------------
    // One beat per operation in flight
    // Slice k fills sum byte k and rewrites carry
    typedef struct packed {
        logic                      valid;
        add_req_pkg::add_op_e      op;
        logic [`ADD_TAG_WIDTH-1:0] tag;
        logic [`ADD_WIDTH-1:0]     a;
        // Second operand, already inverted for subtracts
        logic [`ADD_WIDTH-1:0]     b_eff;
        // Carry into the next slice to run
        logic                      carry;
        // Partial sum, low bytes valid so far
        logic [`ADD_WIDTH-1:0]     sum;
    } add_beat_t;

endpackage

// ==== rtl/brent_kung_adder_8bit.sv ====
// 8-bit Brent-Kung prefix adder with carry in and carry out, combinational
module brent_kung_adder_8bit (
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic       cin,
    output logic [7:0] sum,
    output logic       cout
);

    // Per-bit propagate and generate
    logic [7:0] p0;
    logic [7:0] g0;

    // Level 1 groups of two bits: [1:0], [3:2], [5:4], [7:6]
    logic [3:0] p1;
    logic [3:0] g1;

    // Level 2 groups of four bits: [3:0], [7:4]
    logic [1:0] p2;
    logic [1:0] g2;

    // Level 3 group covering the whole byte
    logic       p3;
    logic       g3;

    // Carry into each bit, bit 8 is the carry out
    logic [8:0] c;

    // ------------------------------
    // Bit level
    // ------------------------------
    assign p0 = a ^ b;
    assign g0 = a & b;

    // ------------------------------
    // Prefix tree, forward pass
    // ------------------------------
    // Upper pair: G = G_hi | P_hi & G_lo, P = P_hi & P_lo
    assign p1[0] = p0[1] & p0[0];
    assign g1[0] = g0[1] | (p0[1] & g0[0]);

    assign p1[1] = p0[3] & p0[2];
    assign g1[1] = g0[3] | (p0[3] & g0[2]);

    assign p1[2] = p0[5] & p0[4];
    assign g1[2] = g0[5] | (p0[5] & g0[4]);

    assign p1[3] = p0[7] & p0[6];
    assign g1[3] = g0[7] | (p0[7] & g0[6]);

    // Merge pairs into nibbles
    assign p2[0] = p1[1] & p1[0];
    assign g2[0] = g1[1] | (p1[1] & g1[0]);

    assign p2[1] = p1[3] & p1[2];
    assign g2[1] = g1[3] | (p1[3] & g1[2]);

    // Merge nibbles into the full byte
    assign p3 = p2[1] & p2[0];
    assign g3 = g2[1] | (p2[1] & g2[0]);

    // ------------------------------
    // Carries, backward pass
    // ------------------------------
    assign c[0] = cin;

    // Power-of-two positions come straight from the tree
    assign c[2] = g1[0] | (p1[0] & c[0]);
    assign c[4] = g2[0] | (p2[0] & c[0]);
    assign c[8] = g3 | (p3 & c[0]);

    // Bit 6 hangs off the nibble carry
    assign c[6] = g1[2] | (p1[2] & c[4]);

    // Odd positions use one more single-bit cell
    assign c[1] = g0[0] | (p0[0] & c[0]);
    assign c[3] = g0[2] | (p0[2] & c[2]);
    assign c[5] = g0[4] | (p0[4] & c[4]);
    assign c[7] = g0[6] | (p0[6] & c[6]);

    // ------------------------------
    // Sum and carry out
    // ------------------------------
    assign sum  = p0 ^ c[7:0];
    assign cout = c[8];

endmodule

// ==== rtl/add_decode_stage.sv ====
// Decode stage: opcode to effective second operand and initial carry, registered
`include "add_defines.svh"

module add_decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  add_req_pkg::add_req_t  in_req,
    output add_beat_pkg::add_beat_t beat
);

    logic [`ADD_WIDTH-1:0] b_eff;
    logic                  carry_init;

    // ------------------------------
    // Operand selection
    // ------------------------------
    // Subtracts are a + ~b + 1, borrow in clears the +1
    always_comb begin
        case (in_req.op)
            add_req_pkg::OP_ADC: begin
                b_eff      = in_req.b;
                carry_init = in_req.carry_in;
            end
            add_req_pkg::OP_SUB,
            add_req_pkg::OP_CMP: begin
                b_eff      = ~in_req.b;
                carry_init = 1'b1;
            end
            add_req_pkg::OP_SBB: begin
                b_eff      = ~in_req.b;
                carry_init = ~in_req.carry_in;
            end
            default: begin
                // Plain ADD
                b_eff      = in_req.b;
                carry_init = 1'b0;
            end
        endcase
    end

    // ------------------------------
    // First beat register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else begin
            beat.valid <= in_valid;
            beat.op    <= in_req.op;
            beat.tag   <= in_req.tag;
            beat.a     <= in_req.a;
            beat.b_eff <= b_eff;
            beat.carry <= carry_init;
            // Slices fill this in byte by byte
            beat.sum   <= '0;
        end
    end

endmodule

// ==== rtl/add_slice_stage.sv ====
// Slice stage: one byte of the add with incoming carry, registered beat out
`include "add_defines.svh"

module add_slice_stage #(
    // Byte this stage owns, 0 is the least significant
    parameter int SLICE_INDEX = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  add_beat_pkg::add_beat_t beat_in,
    output add_beat_pkg::add_beat_t beat_out
);

    // Lowest bit of the owned byte
    localparam int LSB = SLICE_INDEX * `ADD_SLICE_WIDTH;

    logic [`ADD_SLICE_WIDTH-1:0] slice_a;
    logic [`ADD_SLICE_WIDTH-1:0] slice_b;
    logic [`ADD_SLICE_WIDTH-1:0] slice_sum;
    logic                        slice_cout;

    add_beat_pkg::add_beat_t     beat_nxt;

    // ------------------------------
    // Byte add
    // ------------------------------
    assign slice_a = beat_in.a[LSB +: `ADD_SLICE_WIDTH];
    assign slice_b = beat_in.b_eff[LSB +: `ADD_SLICE_WIDTH];

    brent_kung_adder_8bit i_brent_kung_adder_8bit (
        .a    (slice_a),
        .b    (slice_b),
        .cin  (beat_in.carry),
        .sum  (slice_sum),
        .cout (slice_cout)
    );

    // ------------------------------
    // Next beat
    // ------------------------------
    // Other bytes of sum pass through untouched
    always_comb begin
        beat_nxt                              = beat_in;
        beat_nxt.sum[LSB +: `ADD_SLICE_WIDTH] = slice_sum;
        // Carry out of this byte feeds the next slice
        beat_nxt.carry                        = slice_cout;
    end

    // Stage register, advances every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_out <= '0;
        end else begin
            beat_out <= beat_nxt;
        end
    end

endmodule

// ==== rtl/add_flags_stage.sv ====
// Flags stage: zero, negative, carry/borrow and overflow, registered result
`include "add_defines.svh"

module add_flags_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  add_beat_pkg::add_beat_t   beat_in,
    output logic                      out_valid,
    output add_req_pkg::add_result_t  out_result
);

    localparam int MSB = `ADD_WIDTH - 1;

    logic                     is_sub;
    add_req_pkg::add_result_t result_nxt;

    // Subtract family reports borrow instead of carry
    assign is_sub = (beat_in.op == add_req_pkg::OP_SUB) ||
                    (beat_in.op == add_req_pkg::OP_SBB) ||
                    (beat_in.op == add_req_pkg::OP_CMP);

    // ------------------------------
    // Flag logic
    // ------------------------------
    always_comb begin
        result_nxt.tag      = beat_in.tag;
        // Full difference is kept even for CMP
        result_nxt.sum      = beat_in.sum;
        result_nxt.write_en = (beat_in.op != add_req_pkg::OP_CMP);
        result_nxt.zero     = (beat_in.sum == '0);
        result_nxt.negative = beat_in.sum[MSB];
        // Carry from the last slice, inverted to a borrow for subtracts
        result_nxt.carry    = beat_in.carry ^ is_sub;
        // Same-sign operands with a result of the other sign
        result_nxt.overflow = (beat_in.a[MSB] == beat_in.b_eff[MSB]) &&
                              (beat_in.sum[MSB] != beat_in.a[MSB]);
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_result <= '0;
        end else begin
            out_valid  <= beat_in.valid;
            out_result <= result_nxt;
        end
    end

endmodule

// ==== rtl/add_pipe_top.sv ====
// Top level of the add/subtract pipeline: decode, four byte slices, flags
`include "add_defines.svh"

module add_pipe_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  add_req_pkg::add_req_t    in_req,
    output logic                     out_valid,
    output add_req_pkg::add_result_t out_result
);

    // ------------------------------
    // Beat chain
    // ------------------------------
    // beats[0] leaves decode, beats[k+1] leaves slice k
    add_beat_pkg::add_beat_t beats [`ADD_NUM_SLICES+1];

    // First stage picks the operand and carry-in
    add_decode_stage i_add_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_req   (in_req),
        .beat     (beats[0])
    );

    // ------------------------------
    // Byte slices
    // ------------------------------
    // Carry ripples one byte per cycle
    for (genvar k = 0; k < `ADD_NUM_SLICES; k++) begin : g_slice
        add_slice_stage #(
            .SLICE_INDEX (k)
        ) i_add_slice_stage (
            .clk      (clk),
            .rst_n    (rst_n),
            .beat_in  (beats[k]),
            .beat_out (beats[k+1])
        );
    end

    // ------------------------------
    // Flags and result
    // ------------------------------
    add_flags_stage i_add_flags_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_in    (beats[`ADD_NUM_SLICES]),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

// ==== sim/add_pipe_props.sv ====
// Bound assertions: reset, latency, tag, sum, carry/borrow, zero/negative/overflow, write enable
`include "add_defines.svh"

module add_pipe_props (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input add_req_pkg::add_req_t    in_req,
    input logic                     out_valid,
    input add_req_pkg::add_result_t out_result
);

    localparam int LAT = `ADD_LATENCY;
    localparam int MSB = `ADD_WIDTH - 1;

    // Read by the testbench through the bound instance
    int unsigned fail_count = 0;

    // Operands widened by one bit so the carry lands in the top bit
    logic [`ADD_WIDTH:0] opa_ext;
    logic [`ADD_WIDTH:0] opb_ext;
    logic [`ADD_WIDTH:0] wide;
    logic                is_sub;
    logic                borrow_in;

    logic [MSB:0]        exp_sum;
    logic                exp_carry;
    // Zero, negative, overflow
    logic [2:0]          exp_zno;
    logic                exp_write_en;

    // ------------------------------
    // Reference arithmetic
    // ------------------------------
    always_comb begin
        opa_ext   = {1'b0, in_req.a};
        opb_ext   = {1'b0, in_req.b};
        is_sub    = 1'b1;
        borrow_in = 1'b0;
        case (in_req.op)
            add_req_pkg::OP_ADD: begin
                is_sub = 1'b0;
                wide   = opa_ext + opb_ext;
            end
            add_req_pkg::OP_ADC: begin
                is_sub = 1'b0;
                wide   = opa_ext + opb_ext + in_req.carry_in;
            end
            add_req_pkg::OP_SBB: begin
                borrow_in = in_req.carry_in;
                wide      = opa_ext - opb_ext - borrow_in;
            end
            default: begin
                // SUB and CMP
                wide = opa_ext - opb_ext;
            end
        endcase
        exp_sum = wide[MSB:0];
        // Borrow when a is below b plus borrow, unsigned
        exp_carry = is_sub ? (opa_ext < (opb_ext + borrow_in)) : wide[`ADD_WIDTH];
        exp_zno[2] = (exp_sum == '0);
        exp_zno[1] = exp_sum[MSB];
        // Add: same signs in, other sign out; subtract: different signs in
        exp_zno[0] = is_sub ? ((in_req.a[MSB] != in_req.b[MSB]) && (exp_sum[MSB] != in_req.a[MSB]))
                            : ((in_req.a[MSB] == in_req.b[MSB]) && (exp_sum[MSB] != in_req.a[MSB]));
        exp_write_en = (in_req.op != add_req_pkg::OP_CMP);
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("mismatch at %0t: out_valid high during reset", $time);
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: out_valid vs in_valid %0d cycles earlier", $time, LAT);
        end

    a_tag: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_result.tag == $past(in_req.tag, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: tag %0h", $time, out_result.tag);
        end

    a_sum: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_result.sum == $past(exp_sum, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: sum %08h", $time, out_result.sum);
        end

    a_carry: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_result.carry == $past(exp_carry, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: carry/borrow flag", $time);
        end

    a_zno: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> {out_result.zero, out_result.negative, out_result.overflow}
                      == $past(exp_zno, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: zero/negative/overflow flags", $time);
        end

    a_write_en: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_result.write_en == $past(exp_write_en, LAT))
        else begin
            fail_count++;
            $error("mismatch at %0t: write_en", $time);
        end

endmodule

bind add_pipe_top add_pipe_props i_add_pipe_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .out_valid  (out_valid),
    .out_result (out_result)
);

// ==== sim/add_pipe_tb.sv ====
// Testbench for the add pipeline: clock, reset, directed and random tests, report, timeout
`include "add_defines.svh"

module add_pipe_tb;

    localparam int LATENCY       = `ADD_LATENCY;
    localparam int RESET_CYCLES  = 10;
    // Issue slots per test
    localparam int LAT_CYCLES    = 4;
    localparam int CARRY_OPS     = 8;
    localparam int SUB_OPS       = 7;
    localparam int FLAG_OPS      = 6;
    localparam int CMP_OPS       = 5;
    localparam int RANDOM_CYCLES = 200;
    localparam int NUM_TESTS     = 6;
    // Each test also spends one gap plus a drain of up to LATENCY+1 cycles
    localparam int ISSUED_CYCLES = RESET_CYCLES + LAT_CYCLES + CARRY_OPS + SUB_OPS + FLAG_OPS
                                 + CMP_OPS + RANDOM_CYCLES + NUM_TESTS * (LATENCY + 2);
    localparam int CYCLE_LIMIT   = ISSUED_CYCLES + LATENCY + 20;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    add_req_pkg::add_req_t      in_req;
    logic                       out_valid;
    add_req_pkg::add_result_t   out_result;

    logic [`ADD_TAG_WIDTH-1:0]  next_tag = '0;
    int unsigned                issued = 0;
    int unsigned                received = 0;
    int unsigned                cycle_count = 0;
    int unsigned                fails_before = 0;
    int unsigned                failed_tests = 0;
    int unsigned                tests_run = 0;

    add_pipe_top i_add_pipe_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Result counter and timeout
    // ------------------------------
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            received <= received + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic issue_op(input add_req_pkg::add_op_e op, input logic [`ADD_WIDTH-1:0] a,
                            input logic [`ADD_WIDTH-1:0] b, input logic cin);
        @(posedge clk);
        #1;
        in_valid        = 1'b1;
        in_req.op       = op;
        in_req.tag      = next_tag;
        in_req.a        = a;
        in_req.b        = b;
        in_req.carry_in = cin;
        next_tag        = next_tag + 1'b1;
        issued++;
    endtask

    task automatic insert_gap();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Wait until every issued operation has come out
    task automatic drain_pipe();
        insert_gap();
        while (received != issued) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name);
        int unsigned now_fails;
        now_fails = i_add_pipe_top.i_add_pipe_props.fail_count;
        tests_run++;
        if (now_fails != fails_before) begin
            failed_tests++;
        end
        $display("test %-10s done: %0d assertion failures", name, now_fails - fails_before);
        fails_before = now_fails;
    endtask

    // Corner values mixed with plain random words
    function automatic logic [`ADD_WIDTH-1:0] pick_operand();
        case ($urandom % 8)
            0: return 32'h0000_0000;
            1: return 32'hFFFF_FFFF;
            2: return 32'h7FFF_FFFF;
            3: return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    task automatic run_random(input int cycles);
        add_req_pkg::add_op_e      op;
        logic [`ADD_WIDTH-1:0]     a;
        logic [`ADD_WIDTH-1:0]     b;
        logic                      cin;
        for (int i = 0; i < cycles; i++) begin
            op  = add_req_pkg::add_op_e'($urandom % 5);
            a   = pick_operand();
            // Equal operands now and then for the zero flag
            b   = (($urandom % 8) == 0) ? a : pick_operand();
            cin = (($urandom % 2) != 0);
            if (($urandom % 6) == 0) begin
                insert_gap();
            end else begin
                issue_op(op, a, b, cin);
            end
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        void'($urandom(32'h93134e82));
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        // Idle cycles first, out_valid must stay low
        repeat (LAT_CYCLES - 1) insert_gap();
        issue_op(add_req_pkg::OP_ADD, 32'd1, 32'd2, 1'b0);
        drain_pipe();
        report_test("latency");

        // Ripple through all bytes, then each byte boundary alone
        issue_op(add_req_pkg::OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        issue_op(add_req_pkg::OP_ADD, 32'h0000_00FF, 32'h0000_0001, 1'b0);
        issue_op(add_req_pkg::OP_ADD, 32'h0000_FF00, 32'h0000_0100, 1'b0);
        issue_op(add_req_pkg::OP_ADD, 32'h00FF_0000, 32'h0001_0000, 1'b0);
        issue_op(add_req_pkg::OP_ADD, 32'hFF00_0000, 32'h0100_0000, 1'b0);
        issue_op(add_req_pkg::OP_ADC, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
        issue_op(add_req_pkg::OP_ADC, 32'h0000_FFFF, 32'h0000_0000, 1'b1);
        issue_op(add_req_pkg::OP_ADC, 32'h1234_5678, 32'h8765_4321, 1'b1);
        drain_pipe();
        report_test("carry");

        issue_op(add_req_pkg::OP_SUB, 32'd5, 32'd3, 1'b0);
        issue_op(add_req_pkg::OP_SUB, 32'd3, 32'd5, 1'b0);
        issue_op(add_req_pkg::OP_SUB, 32'd0, 32'd1, 1'b0);
        issue_op(add_req_pkg::OP_SBB, 32'd5, 32'd5, 1'b1);
        issue_op(add_req_pkg::OP_SBB, 32'd5, 32'd4, 1'b1);
        issue_op(add_req_pkg::OP_SBB, 32'd0, 32'hFFFF_FFFF, 1'b1);
        issue_op(add_req_pkg::OP_SBB, 32'h0000_0100, 32'd1, 1'b0);
        drain_pipe();
        report_test("subtract");

        issue_op(add_req_pkg::OP_ADD, 32'h7FFF_FFFF, 32'd1, 1'b0);
        issue_op(add_req_pkg::OP_SUB, 32'h8000_0000, 32'd1, 1'b0);
        issue_op(add_req_pkg::OP_SUB, 32'h1234_5678, 32'h1234_5678, 1'b0);
        issue_op(add_req_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000, 1'b0);
        issue_op(add_req_pkg::OP_ADD, 32'hFFFF_FFFF, 32'd1, 1'b0);
        issue_op(add_req_pkg::OP_ADC, 32'h7FFF_FFFF, 32'd0, 1'b1);
        drain_pipe();
        report_test("flags");

        issue_op(add_req_pkg::OP_CMP, 32'd10, 32'd20, 1'b0);
        issue_op(add_req_pkg::OP_CMP, 32'd20, 32'd10, 1'b0);
        issue_op(add_req_pkg::OP_CMP, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b0);
        issue_op(add_req_pkg::OP_CMP, 32'h8000_0000, 32'd1, 1'b0);
        issue_op(add_req_pkg::OP_SUB, 32'h8000_0000, 32'd1, 1'b0);
        drain_pipe();
        report_test("compare");

        run_random(RANDOM_CYCLES);
        drain_pipe();
        report_test("random");

        $display("Summary: %0d tests, %0d failing, %0d assertion failures, %0d results",
                 tests_run, failed_tests, i_add_pipe_top.i_add_pipe_props.fail_count, received);
        if (failed_tests == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
rtl/add_req_pkg.sv
rtl/add_beat_pkg.sv
rtl/brent_kung_adder_8bit.sv
rtl/add_decode_stage.sv
rtl/add_slice_stage.sv
rtl/add_flags_stage.sv
rtl/add_pipe_top.sv
sim/add_pipe_props.sv
sim/add_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: add_pipe

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/add_req_pkg.sv
      - rtl/add_beat_pkg.sv
      - rtl/brent_kung_adder_8bit.sv
      - rtl/add_decode_stage.sv
      - rtl/add_slice_stage.sv
      - rtl/add_flags_stage.sv
      - rtl/add_pipe_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/add_pipe_props.sv
      - sim/add_pipe_tb.sv
